// File: compile.f
src/rv32i_pkg.sv
src/inst_queue.sv
src/ir_decode.sv
src/control_rom.sv
src/regfile.sv
src/execute.sv
src/rv32i_core.sv
tb/core_properties.sv
tb/tb_core.sv

// File: Makefile
TOP = tb_core

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build folder and the simulation log"

obj_dir/V$(TOP): compile.f src/*.sv tb/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Something failed" sim.log; then echo "FAIL"; exit 1; fi
	@if ! grep -q "Everything OK" sim.log; then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir sim.log

// File: tb/tb_core.sv
`default_nettype none

module tb_core;
    localparam int N_INST      = 400;
    localparam int CYCLE_LIMIT = 10 * N_INST + 200;

    logic                 clk;
    logic                 rst_n;
    logic                 inst_valid;
    rv32i_pkg::rv32i_word inst;
    logic                 inst_credit;
    logic                 retire_valid;
    rv32i_pkg::retire_t   retire;
    logic                 retire_credit;

    rv32i_pkg::retire_t   exp_q[$];
    string                name_q[$];
    rv32i_pkg::rv32i_word ref_regs [32];
    rv32i_pkg::rv32i_word model_pc;
    logic [15:0]          lfsr;
    logic [4:0]           last_rd;
    int                   in_credits;  // Input credits the driver holds
    int                   owed;        // Retire credits not yet handed back
    int                   hold_left;
    int                   sent;
    int                   received;
    int                   cycles;

    rv32i_core dut0 (
        .clk, .rst_n, .inst_valid, .inst, .inst_credit,
        .retire_valid, .retire, .retire_credit
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("Timeout: %0d of %0d records retired after %0d cycles",
                     received, N_INST, cycles);
            $display("Something failed");
            $fatal(1);
        end
    end

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic rv32i_pkg::rv32i_word arith_result(input logic [2:0] f3,
                                                          input rv32i_pkg::rv32i_word a,
                                                          input rv32i_pkg::rv32i_word b,
                                                          input logic alt);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'd0, $signed(a) < $signed(b)};
            3'b011:  return {31'd0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3,
                                          input rv32i_pkg::rv32i_word a,
                                          input rv32i_pkg::rv32i_word b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic make_instruction(output rv32i_pkg::rv32i_word w, output string kind);
        logic [3:0]  pick;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [6:0]  f7;
        logic [12:0] off;
        pick = 4'(take_bits(4));
        rd   = 5'(take_bits(3));  // x0 to x7 keeps operands and results colliding
        rs1  = 5'(take_bits(3));
        rs2  = 5'(take_bits(3));
        f3   = 3'(take_bits(3));
        imm  = 12'(take_bits(12));
        off  = {12'(take_bits(12)), 1'b0};
        f7   = 7'h00;
        if (take_bits(1) != 0)
            imm = {{8{imm[11]}}, imm[3:0]};  // Small values
        if ((f3 == 3'b000 || f3 == 3'b101) && take_bits(1) != 0)
            f7 = 7'h20;
        if (pick == 4'd15)
        begin
            rs1 = last_rd;  // Reads what the previous instruction wrote
            rs2 = last_rd;
        end
        if (pick < 4'd5)
        begin
            if (f3 == 3'b001 || f3 == 3'b101)
                imm = {f7, imm[4:0]};  // Shift amount plus the sra bit
            w = {imm, rs1, f3, rd, 7'b0010011};
            kind = "op_imm";
        end
        else if (pick < 4'd9 || pick == 4'd15)
        begin
            w = {f7, rs2, rs1, f3, rd, 7'b0110011};
            if (pick == 4'd15)
                kind = "dependency";
            else
                kind = "op";
        end
        else if (pick == 4'd9)
        begin
            w = {20'(take_bits(20)), rd, 7'b0110111};
            kind = "lui";
        end
        else if (pick == 4'd10)
        begin
            w = {20'(take_bits(20)), rd, 7'b0010111};
            kind = "auipc";
        end
        else if (pick < 4'd14)
        begin
            if (f3[2:1] == 2'b01)
                f3 = f3 ^ 3'b110;  // No branch kinds at 010 and 011
            if (take_bits(2) == 0)
                rs2 = rs1;
            w = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
            kind = "branch";
        end
        else
        begin
            w = {25'(take_bits(25)), 7'b0000011};  // Load, not supported by the core
            kind = "illegal";
        end
        last_rd = rd;
    endtask

    task automatic predict_record(input rv32i_pkg::rv32i_word w, input string name);
        rv32i_pkg::retire_t   r;
        rv32i_pkg::rv32i_word a;
        rv32i_pkg::rv32i_word b;
        rv32i_pkg::rv32i_word i_imm;
        rv32i_pkg::rv32i_word u_imm;
        rv32i_pkg::rv32i_word b_imm;
        rv32i_pkg::rv32i_word res;
        logic                 writes;
        a         = ref_regs[w[19:15]];
        b         = ref_regs[w[24:20]];
        i_imm     = {{20{w[31]}}, w[31:20]};
        u_imm     = {w[31:12], 12'h000};
        b_imm     = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        res       = '0;
        writes    = 1'b1;
        r.pc      = model_pc;
        r.rd      = w[11:7];
        r.next_pc = model_pc + 32'd4;
        r.illegal = 1'b0;
        case (w[6:0])
            7'b0110111: res = u_imm;
            7'b0010111: res = model_pc + u_imm;
            7'b0010011: res = arith_result(w[14:12], a, i_imm, w[14:12] == 3'b101 && w[30]);
            7'b0110011: res = arith_result(w[14:12], a, b, w[30]);
            7'b1100011:
            begin
                writes = 1'b0;
                if (branch_taken(w[14:12], a, b))
                    r.next_pc = model_pc + b_imm;
            end
            default:
            begin
                writes    = 1'b0;  // Retires as illegal with no destination
                r.rd      = '0;
                r.illegal = 1'b1;
            end
        endcase
        r.we    = writes && r.rd != '0;
        r.value = r.we ? res : '0;
        if (r.we)
            ref_regs[r.rd] = res;
        model_pc = r.next_pc;
        exp_q.push_back(r);
        name_q.push_back(name);
    endtask

    task automatic report_mismatch(input string test, input string field,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("ERROR %s %s expected %h actual %h", test, field, expected, actual);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_record(input rv32i_pkg::retire_t act);
        rv32i_pkg::retire_t exp;
        string              name;
        if (exp_q.size() == 0)
        begin
            $display("A retire record arrived with no instruction left to retire");
            $display("Something failed");
            $fatal(1);
        end
        else
        begin
            exp  = exp_q.pop_front();
            name = name_q.pop_front();
            assert (act.pc == exp.pc)
                else report_mismatch(name, "pc", exp.pc, act.pc);
            assert (act.rd == exp.rd)
                else report_mismatch(name, "rd", 32'(exp.rd), 32'(act.rd));
            assert (act.we == exp.we)
                else report_mismatch(name, "we", 32'(exp.we), 32'(act.we));
            assert (act.value == exp.value)
                else report_mismatch(name, "value", exp.value, act.value);
            assert (act.next_pc == exp.next_pc)
                else report_mismatch(name, "next_pc", exp.next_pc, act.next_pc);
            assert (act.illegal == exp.illegal)
                else report_mismatch(name, "illegal", 32'(exp.illegal), 32'(act.illegal));
            received++;
        end
    endtask

    task automatic step_cycle;
        logic                 credit_seen;
        logic                 beat;
        rv32i_pkg::retire_t   got;
        rv32i_pkg::rv32i_word word;
        string                kind;
        @(negedge clk);
        credit_seen = inst_credit;  // Registered outputs, settled since the rising edge
        beat        = retire_valid;
        got         = retire;
        if (beat)
            check_record(got);
        if (sent < N_INST && in_credits > 0 && take_bits(2) != 0)
        begin
            make_instruction(word, kind);
            predict_record(word, $sformatf("%s #%0d", kind, sent));
            inst_valid = 1'b1;
            inst       = word;
            in_credits--;
            sent++;
        end
        else
            inst_valid = 1'b0;
        if (credit_seen)
            in_credits++;  // Usable from the next beat on
        // Retire credits return at random, with long holds for back-pressure
        if (hold_left > 0)
        begin
            hold_left--;
            retire_credit = 1'b0;
        end
        else if (owed > 0 && take_bits(2) != 0)
        begin
            retire_credit = 1'b1;
            owed--;
        end
        else
            retire_credit = 1'b0;
        if (hold_left == 0 && take_bits(5) == 0)
            hold_left = 16 + int'(take_bits(5));
        if (beat)
            owed++;
    endtask

    initial
    begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        inst_valid    = 1'b0;
        inst          = '0;
        retire_credit = 1'b0;
        lfsr          = 16'd48501;
        model_pc      = rv32i_pkg::RESET_PC;
        last_rd       = '0;
        in_credits    = rv32i_pkg::QUEUE_DEPTH;
        owed          = 0;
        hold_left     = 0;
        sent          = 0;
        received      = 0;
        cycles        = 0;
        for (int i = 0; i < 32; i++)
            ref_regs[i] = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        while (received < N_INST)
            step_cycle();
        repeat (30)
            step_cycle();  // A duplicated record would show up here
        if (sent == N_INST && received == N_INST && exp_q.size() == 0)
        begin
            $display("Everything OK");
            $finish;
        end
        else
        begin
            $display("Records sent %0d, retired %0d, still expected %0d",
                     sent, received, exp_q.size());
            $display("Something failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// File: tb/core_properties.sv
`default_nettype none

module core_properties (
    input logic               clk,
    input logic               rst_n,
    input logic               inst_valid,
    input logic               inst_credit,
    input logic               retire_valid,
    input rv32i_pkg::retire_t retire,
    input logic               retire_credit
);
    int queue_fill;  // Pushed entries not yet popped
    int credits;     // Retire credits the core should hold

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            queue_fill <= 0;
            credits    <= rv32i_pkg::RETIRE_CREDITS;
        end
        else
        begin
            queue_fill <= queue_fill + int'(inst_valid) - int'(inst_credit);
            credits    <= credits - int'(retire_valid) + int'(retire_credit);
        end
    end

    no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid |-> queue_fill < rv32i_pkg::QUEUE_DEPTH)
        else $error("Instruction written into a full queue");

    no_retire_without_credit: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> credits > 0)
        else $error("Retire beat sent with no credit left");

    no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> !(retire.we && retire.rd == '0))
        else $error("Retire record writes x0");

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |=> !inst_credit && !retire_valid)
        else $error("Credit or retire pulse right after a reset edge");

endmodule

bind rv32i_core core_properties props0 (
    .clk, .rst_n, .inst_valid, .inst_credit, .retire_valid, .retire, .retire_credit
);

`default_nettype wire

// File: src/rv32i_core.sv
`default_nettype none

module rv32i_core (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 inst_valid,
    input  rv32i_pkg::rv32i_word inst,
    output logic                 inst_credit,
    output logic                 retire_valid,
    output rv32i_pkg::retire_t   retire,
    input  logic                 retire_credit
);
    rv32i_pkg::rv32i_word  head;
    logic                  not_empty;
    logic                  pop;
    logic                  stall;
    rv32i_pkg::reg_idx_t   rs1;
    rv32i_pkg::reg_idx_t   rs2;
    rv32i_pkg::rv32i_word  rs1_val;
    rv32i_pkg::rv32i_word  rs2_val;
    rv32i_pkg::rv32i_word  i_imm;
    rv32i_pkg::rv32i_word  s_imm;
    rv32i_pkg::rv32i_word  b_imm;
    rv32i_pkg::rv32i_word  u_imm;
    rv32i_pkg::ctrl_word_t ctrl;
    logic                  wr_en;
    rv32i_pkg::reg_idx_t   wr_idx;
    rv32i_pkg::rv32i_word  wr_data;
    rv32i_pkg::rv32i_word  next_pc;
    rv32i_pkg::rv32i_word  pc_q;
    rv32i_pkg::rv32i_word  pc_issue;
    rv32i_pkg::dec_stage_t dec_q;

    assign pop = not_empty && !stall;

    // Instruction in execute hands its next_pc straight to the one being popped
    assign pc_issue = dec_q.valid ? next_pc : pc_q;

    inst_queue queue0 (.clk, .rst_n, .inst_valid, .inst, .pop, .head, .not_empty, .inst_credit);

    ir_decode decode0 (.inst(head), .rs1, .rs2, .i_imm, .s_imm, .b_imm, .u_imm);

    control_rom rom0 (.inst(head), .ctrl);

    regfile regs0 (.clk, .rst_n, .rs1, .rs2, .rs1_val, .rs2_val, .wr_en, .wr_idx, .wr_data);

    execute exec0 (
        .clk, .rst_n, .dec(dec_q), .stall, .wr_en, .wr_idx, .wr_data, .next_pc,
        .retire_valid, .retire, .retire_credit
    );

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            pc_q        <= rv32i_pkg::RESET_PC;
            dec_q.valid <= 1'b0;
        end
        else if (!stall)
        begin
            if (dec_q.valid)
                pc_q <= next_pc;
            dec_q.valid <= not_empty;
        end
        if (pop)
        begin
            dec_q.pc      <= pc_issue;
            dec_q.ctrl    <= ctrl;
            dec_q.rs1_val <= rs1_val;
            dec_q.rs2_val <= rs2_val;
            dec_q.i_imm   <= i_imm;
            dec_q.s_imm   <= s_imm;
            dec_q.b_imm   <= b_imm;
            dec_q.u_imm   <= u_imm;
        end
    end

endmodule

`default_nettype wire

// File: src/execute.sv
`default_nettype none

module execute (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv32i_pkg::dec_stage_t dec,
    output logic                  stall,
    output logic                  wr_en,
    output rv32i_pkg::reg_idx_t   wr_idx,
    output rv32i_pkg::rv32i_word  wr_data,
    output rv32i_pkg::rv32i_word  next_pc,
    output logic                  retire_valid,
    output rv32i_pkg::retire_t    retire,
    input  logic                  retire_credit
);
    rv32i_pkg::rv32i_word  alu_a;
    rv32i_pkg::rv32i_word  alu_b;
    rv32i_pkg::rv32i_word  cmp_b;
    rv32i_pkg::rv32i_word  alu_out;
    rv32i_pkg::rv32i_word  result;
    rv32i_pkg::rv32i_word  pc_plus4;
    rv32i_pkg::retire_cnt_t credits;
    logic                  br_en;
    logic                  we;
    logic                  capture;
    logic                  rec_valid;

    assign alu_a = (dec.ctrl.alumux1_sel == rv32i_pkg::alumux1_pc_out) ? dec.pc : dec.rs1_val;
    assign cmp_b = (dec.ctrl.cmpmux_sel == rv32i_pkg::cmpmux_i_imm) ? dec.i_imm : dec.rs2_val;
    assign pc_plus4 = dec.pc + 32'd4;

    always_comb
    begin
        case (dec.ctrl.alumux2_sel)
            rv32i_pkg::alumux2_u_imm:   alu_b = dec.u_imm;
            rv32i_pkg::alumux2_b_imm:   alu_b = dec.b_imm;
            rv32i_pkg::alumux2_s_imm:   alu_b = dec.s_imm;
            rv32i_pkg::alumux2_rs2_out: alu_b = dec.rs2_val;
            default:                    alu_b = dec.i_imm;
        endcase
    end

    always_comb
    begin
        case (dec.ctrl.aluop)
            rv32i_pkg::alu_add: alu_out = alu_a + alu_b;
            rv32i_pkg::alu_sll: alu_out = alu_a << alu_b[4:0];
            rv32i_pkg::alu_sra: alu_out = $unsigned($signed(alu_a) >>> alu_b[4:0]);
            rv32i_pkg::alu_sub: alu_out = alu_a - alu_b;
            rv32i_pkg::alu_xor: alu_out = alu_a ^ alu_b;
            rv32i_pkg::alu_srl: alu_out = alu_a >> alu_b[4:0];
            rv32i_pkg::alu_or:  alu_out = alu_a | alu_b;
            default:            alu_out = alu_a & alu_b;
        endcase
    end

    always_comb
    begin
        case (dec.ctrl.cmpop)
            rv32i_pkg::beq:  br_en = (dec.rs1_val == cmp_b);
            rv32i_pkg::bne:  br_en = (dec.rs1_val != cmp_b);
            rv32i_pkg::blt:  br_en = ($signed(dec.rs1_val) < $signed(cmp_b));
            rv32i_pkg::bge:  br_en = ($signed(dec.rs1_val) >= $signed(cmp_b));
            rv32i_pkg::bltu: br_en = (dec.rs1_val < cmp_b);
            rv32i_pkg::bgeu: br_en = (dec.rs1_val >= cmp_b);
            default:         br_en = 1'b0;
        endcase
    end

    always_comb
    begin
        case (dec.ctrl.regfilemux_sel)
            rv32i_pkg::regfilemux_br_en: result = {31'd0, br_en};
            rv32i_pkg::regfilemux_u_imm: result = dec.u_imm;
            default:                     result = alu_out;
        endcase
    end

    assign next_pc = (dec.ctrl.pcmux_sel == rv32i_pkg::pcmux_alu_out && br_en) ? alu_out
                                                                                : pc_plus4;

    assign retire_valid = rec_valid && (credits != '0);
    assign stall        = rec_valid && (credits == '0);  // Record waiting on a credit
    assign capture      = dec.valid && !stall;
    assign we           = dec.ctrl.load_regfile && (dec.ctrl.rd != '0);

    assign wr_en   = capture && we;
    assign wr_idx  = dec.ctrl.rd;
    assign wr_data = result;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            credits   <= rv32i_pkg::retire_cnt_t'(rv32i_pkg::RETIRE_CREDITS);
            rec_valid <= 1'b0;
        end
        else
        begin
            credits   <= credits - retire_valid + retire_credit;
            rec_valid <= capture || stall;
        end
    end

    always_ff @(posedge clk)
    begin
        if (capture)
        begin
            retire.pc      <= dec.pc;
            retire.rd      <= dec.ctrl.rd;
            retire.value   <= we ? result : '0;
            retire.we      <= we;
            retire.next_pc <= next_pc;
            retire.illegal <= dec.ctrl.illegal;
        end
    end

endmodule

`default_nettype wire

// File: src/regfile.sv
`default_nettype none

module regfile (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv32i_pkg::reg_idx_t  rs1,
    input  rv32i_pkg::reg_idx_t  rs2,
    output rv32i_pkg::rv32i_word rs1_val,
    output rv32i_pkg::rv32i_word rs2_val,
    input  logic                 wr_en,
    input  rv32i_pkg::reg_idx_t  wr_idx,
    input  rv32i_pkg::rv32i_word wr_data
);
    rv32i_pkg::rv32i_word regs [32];

    function automatic rv32i_pkg::rv32i_word read_port(rv32i_pkg::reg_idx_t idx);
        if (idx == '0)
            return '0;
        if (wr_en && wr_idx == idx)
            return wr_data;  // Same-cycle write wins
        return regs[idx];
    endfunction

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wr_en && wr_idx != '0)
            regs[wr_idx] <= wr_data;
    end

    always_comb
    begin
        rs1_val = read_port(rs1);
        rs2_val = read_port(rs2);
    end

endmodule

`default_nettype wire

// File: src/control_rom.sv
`default_nettype none

module control_rom (
    input  rv32i_pkg::rv32i_word  inst,
    output rv32i_pkg::ctrl_word_t ctrl
);
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    function automatic rv32i_pkg::ctrl_word_t load_rf(rv32i_pkg::ctrl_word_t c,
                                                      rv32i_pkg::regfilemux_sel_t sel);
        rv32i_pkg::ctrl_word_t r;
        r = c;
        r.load_regfile = 1'b1;
        r.regfilemux_sel = sel;
        return r;
    endfunction

    function automatic rv32i_pkg::ctrl_word_t set_alu(rv32i_pkg::ctrl_word_t c,
                                                      rv32i_pkg::alumux1_sel_t sel1,
                                                      rv32i_pkg::alumux2_sel_t sel2,
                                                      rv32i_pkg::alu_ops op);
        rv32i_pkg::ctrl_word_t r;
        r = c;
        r.alumux1_sel = sel1;
        r.alumux2_sel = sel2;
        r.aluop = op;
        return r;
    endfunction

    function automatic rv32i_pkg::ctrl_word_t set_cmp(rv32i_pkg::ctrl_word_t c,
                                                      rv32i_pkg::cmpmux_sel_t sel,
                                                      rv32i_pkg::branch_funct3_t op);
        rv32i_pkg::ctrl_word_t r;
        r = c;
        r.cmpmux_sel = sel;
        r.cmpop = op;
        return r;
    endfunction

    // OP and OP-IMM differ only in the second operand and in sub
    function automatic rv32i_pkg::ctrl_word_t arith(rv32i_pkg::ctrl_word_t c,
                                                    logic [2:0] f3,
                                                    logic f7_b5,
                                                    logic is_reg);
        rv32i_pkg::ctrl_word_t   r;
        rv32i_pkg::alumux2_sel_t sel2;
        rv32i_pkg::cmpmux_sel_t  csel;
        sel2 = is_reg ? rv32i_pkg::alumux2_rs2_out : rv32i_pkg::alumux2_i_imm;
        csel = is_reg ? rv32i_pkg::cmpmux_rs2_out : rv32i_pkg::cmpmux_i_imm;
        r = c;
        unique case (rv32i_pkg::arith_funct3_t'(f3))
            rv32i_pkg::a_slt:
                r = set_cmp(load_rf(r, rv32i_pkg::regfilemux_br_en), csel, rv32i_pkg::blt);
            rv32i_pkg::a_sltu:
                r = set_cmp(load_rf(r, rv32i_pkg::regfilemux_br_en), csel, rv32i_pkg::bltu);
            rv32i_pkg::a_sr:
            begin
                r = load_rf(r, rv32i_pkg::regfilemux_alu_out);
                r = set_alu(r, rv32i_pkg::alumux1_rs1_out, sel2,
                            f7_b5 ? rv32i_pkg::alu_sra : rv32i_pkg::alu_srl);
            end
            rv32i_pkg::a_add:
            begin
                r = load_rf(r, rv32i_pkg::regfilemux_alu_out);
                r = set_alu(r, rv32i_pkg::alumux1_rs1_out, sel2,
                            (is_reg && f7_b5) ? rv32i_pkg::alu_sub : rv32i_pkg::alu_add);
            end
            default:
            begin
                r = load_rf(r, rv32i_pkg::regfilemux_alu_out);
                r = set_alu(r, rv32i_pkg::alumux1_rs1_out, sel2, rv32i_pkg::alu_ops'(f3));
            end
        endcase
        return r;
    endfunction

    always_comb
    begin
        ctrl = '0;  // All mux selects at their zero defaults
        ctrl.opcode = rv32i_pkg::rv32i_opcode'(inst[6:0]);
        ctrl.rd = inst[11:7];
        ctrl.cmpop = rv32i_pkg::branch_funct3_t'(funct3);
        ctrl.aluop = rv32i_pkg::alu_add;
        case (ctrl.opcode)
            rv32i_pkg::op_lui:
                ctrl = load_rf(ctrl, rv32i_pkg::regfilemux_u_imm);
            rv32i_pkg::op_auipc:
            begin
                ctrl = load_rf(ctrl, rv32i_pkg::regfilemux_alu_out);
                ctrl = set_alu(ctrl, rv32i_pkg::alumux1_pc_out, rv32i_pkg::alumux2_u_imm,
                               rv32i_pkg::alu_add);
            end
            rv32i_pkg::op_br:
            begin
                // ALU forms the target, comparator decides
                ctrl = set_alu(ctrl, rv32i_pkg::alumux1_pc_out, rv32i_pkg::alumux2_b_imm,
                               rv32i_pkg::alu_add);
                ctrl = set_cmp(ctrl, rv32i_pkg::cmpmux_rs2_out,
                               rv32i_pkg::branch_funct3_t'(funct3));
                ctrl.pcmux_sel = rv32i_pkg::pcmux_alu_out;
            end
            rv32i_pkg::op_imm:
                ctrl = arith(ctrl, funct3, funct7[5], 1'b0);
            rv32i_pkg::op_reg:
                ctrl = arith(ctrl, funct3, funct7[5], 1'b1);
            default:
            begin
                ctrl = '0;  // Loads, stores, jumps and system land here
                ctrl.illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/ir_decode.sv
`default_nettype none

module ir_decode (
    input  rv32i_pkg::rv32i_word inst,
    output rv32i_pkg::reg_idx_t  rs1,
    output rv32i_pkg::reg_idx_t  rs2,
    output rv32i_pkg::rv32i_word i_imm,
    output rv32i_pkg::rv32i_word s_imm,
    output rv32i_pkg::rv32i_word b_imm,
    output rv32i_pkg::rv32i_word u_imm
);

    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];

    // Immediates, all sign extended from bit 31
    assign i_imm = {{21{inst[31]}}, inst[30:20]};
    assign s_imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};

    // Branch offset is always even
    assign b_imm = {
        {20{inst[31]}},
        inst[7],
        inst[30:25],
        inst[11:8],
        1'b0
    };

    assign u_imm = {inst[31:12], 12'h000};  // Upper twenty bits

endmodule

`default_nettype wire

// File: src/inst_queue.sv
`default_nettype none

module inst_queue (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 inst_valid,
    input  rv32i_pkg::rv32i_word inst,
    input  logic                 pop,
    output rv32i_pkg::rv32i_word head,
    output logic                 not_empty,
    output logic                 inst_credit
);
    rv32i_pkg::rv32i_word mem [rv32i_pkg::QUEUE_DEPTH];
    rv32i_pkg::qptr_t     wr_ptr;
    rv32i_pkg::qptr_t     rd_ptr;
    rv32i_pkg::qcnt_t     count;
    logic                 do_pop;

    function automatic rv32i_pkg::qptr_t next_ptr(rv32i_pkg::qptr_t p);
        if (p == rv32i_pkg::qptr_t'(rv32i_pkg::QUEUE_DEPTH - 1))
            return '0;
        return p + 1'b1;
    endfunction

    assign not_empty   = (count != '0);
    assign head        = mem[rd_ptr];
    assign do_pop      = pop && not_empty;
    assign inst_credit = do_pop;  // One credit back per pop

    always_ff @(posedge clk)
    begin
        if (inst_valid)
            mem[wr_ptr] <= inst;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (inst_valid)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({inst_valid, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Push and pop cancel
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  reg_idx_t;

    localparam int QUEUE_DEPTH    = 4;  // Input credits after reset
    localparam int RETIRE_CREDITS = 2;  // Output credits after reset
    localparam rv32i_word RESET_PC = 32'h0000_1000;

    localparam int QPTR_W = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int RCNT_W = $clog2(RETIRE_CREDITS + 1);

    typedef logic [QPTR_W-1:0] qptr_t;
    typedef logic [QCNT_W-1:0] qcnt_t;
    typedef logic [RCNT_W-1:0] retire_cnt_t;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_csr   = 7'b1110011
    } rv32i_opcode;

    typedef enum logic [2:0] {
        a_add  = 3'b000,  // Also sub on OP with funct7[5]
        a_sll  = 3'b001,
        a_slt  = 3'b010,
        a_sltu = 3'b011,
        a_xor  = 3'b100,
        a_sr   = 3'b101,  // srl or sra
        a_or   = 3'b110,
        a_and  = 3'b111
    } arith_funct3_t;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    // Same order as funct3 so most ops cast straight across
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_ops;

    typedef enum logic {alumux1_rs1_out, alumux1_pc_out} alumux1_sel_t;

    typedef enum logic [2:0] {
        alumux2_i_imm, alumux2_u_imm, alumux2_b_imm, alumux2_s_imm, alumux2_rs2_out
    } alumux2_sel_t;

    typedef enum logic {cmpmux_rs2_out, cmpmux_i_imm} cmpmux_sel_t;

    typedef enum logic [1:0] {
        regfilemux_alu_out, regfilemux_br_en, regfilemux_u_imm
    } regfilemux_sel_t;

    typedef enum logic {pcmux_pc_plus4, pcmux_alu_out} pcmux_sel_t;

    typedef struct packed {
        rv32i_opcode     opcode;
        alu_ops          aluop;
        branch_funct3_t  cmpop;
        alumux1_sel_t    alumux1_sel;
        alumux2_sel_t    alumux2_sel;
        cmpmux_sel_t     cmpmux_sel;
        regfilemux_sel_t regfilemux_sel;
        pcmux_sel_t      pcmux_sel;
        logic            load_regfile;
        reg_idx_t        rd;
        logic            illegal;
    } ctrl_word_t;

    typedef struct packed {
        logic       valid;
        rv32i_word  pc;
        ctrl_word_t ctrl;
        rv32i_word  rs1_val;
        rv32i_word  rs2_val;
        rv32i_word  i_imm;
        rv32i_word  s_imm;
        rv32i_word  b_imm;
        rv32i_word  u_imm;
    } dec_stage_t;

    typedef struct packed {
        rv32i_word pc;
        reg_idx_t  rd;
        rv32i_word value;
        logic      we;
        rv32i_word next_pc;
        logic      illegal;
    } retire_t;

endpackage

`default_nettype wire
